/* hdl/hexio_pkg.sv */
// ascii only; chars are 8 bits and hex digits may be upper or lower case on input
package hexio_pkg;

  typedef logic [7:0] char_t;

  // ************************************************************************
  // framing characters of the text file
  // ************************************************************************
  localparam char_t ch_soh     = 8'h01; // start of header
  localparam char_t ch_sot     = 8'h02; // start of text
  localparam char_t ch_eot     = 8'h03; // end of title
  localparam char_t ch_eof     = 8'h04; // end of file
  localparam char_t ch_lf      = 8'h0a;
  localparam char_t ch_cr      = 8'h0d;
  localparam char_t ch_file_id = 8'h30; // single memory, so name is always '0'

  // ************************************************************************
  // state encodings
  // ************************************************************************
  typedef enum logic [1:0] {wait_sot, collect, write_req, write_wait} loader_state_e;

  typedef enum logic [2:0] {idle, header, line, read_req, read_wait, trailer} dumper_state_e;

  // release_bus is the ack-low turnaround before the next grant
  typedef enum logic [1:0] {free, grant_load, grant_dump, release_bus} arb_state_e;

  // {valid, value}; valid low for anything outside 0-9, a-f, A-F
  function automatic logic [4:0] hex_to_nibble(input char_t c);
    if (c >= 8'h30 && c <= 8'h39) begin
      return {1'b1, c[3:0]};
    end else if ((c >= 8'h41 && c <= 8'h46) || (c >= 8'h61 && c <= 8'h66)) begin
      return {1'b1, c[3:0] + 4'h9}; // 'a'/'A' low nibble is 1 -> 10
    end
    return 5'b0_0000;
  endfunction

  // always upper case out
  function automatic char_t nibble_to_hex(input logic [3:0] v);
    return (v < 4'ha) ? 8'h30 + char_t'(v) : 8'h37 + char_t'(v);
  endfunction

endpackage

/* hdl/word_ram.sv */
// one port, read data registered every cycle; a write returns the old word at that address
module word_ram #(
  parameter int  WORD_NIBBLES = 4,
  parameter int  DEPTH        = 16,
  localparam int WW           = 4 * WORD_NIBBLES,
  localparam int AW           = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic          clk_sys,
  input  logic          we_i,
  input  logic [AW-1:0] addr_i,
  input  logic [WW-1:0] wdata_i,
  output logic [WW-1:0] rdata_o
);

  logic [WW-1:0] mem [DEPTH]; // word array, contents undefined until loaded

  always_ff @(posedge clk_sys) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
    // read first, so same-address write shows next access
    rdata_o <= mem[addr_i];
  end

endmodule

/* hdl/mem_arbiter.sv */
// four-phase req/ack, loader has priority; a client must hold addr/data stable while req is high
module mem_arbiter #(
  parameter int  WORD_NIBBLES = 4,
  parameter int  DEPTH        = 16,
  localparam int WW           = 4 * WORD_NIBBLES,
  localparam int AW           = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic          clk_sys,
  input  logic          rst_clk,
  input  logic          load_req_i,
  input  logic [AW-1:0] load_addr_i,
  input  logic [WW-1:0] load_wdata_i,
  output logic          load_ack_o,
  input  logic          dump_req_i,
  input  logic [AW-1:0] dump_addr_i,
  output logic          dump_ack_o,
  output logic [WW-1:0] dump_rdata_o,
  output logic          ram_we_o,
  output logic [AW-1:0] ram_addr_o,
  output logic [WW-1:0] ram_wdata_o,
  input  logic [WW-1:0] ram_rdata_i
);
  import hexio_pkg::*;

  arb_state_e state_q;
  logic       load_ack_q;
  logic       dump_ack_q;
  logic       pick_load; // loader takes a free bus this cycle

  assign pick_load = (state_q == free) && load_req_i;

  // ram access goes out in the grant cycle, ack follows a cycle later
  assign ram_we_o     = pick_load;                   // only writes come from the loader
  assign ram_addr_o   = (pick_load || state_q == grant_load) ? load_addr_i : dump_addr_i;
  assign ram_wdata_o  = load_wdata_i;
  assign dump_rdata_o = ram_rdata_i; // stays valid while dump addr is held
  assign load_ack_o   = load_ack_q;
  assign dump_ack_o   = dump_ack_q;

  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      state_q    <= free;
      load_ack_q <= 1'b0;
      dump_ack_q <= 1'b0;
    end else begin
      case (state_q)
        free: begin
          if (load_req_i) begin
            state_q    <= grant_load;
            load_ack_q <= 1'b1;
          end else if (dump_req_i) begin
            state_q    <= grant_dump;
            dump_ack_q <= 1'b1;
          end
        end
        grant_load: if (!load_req_i) begin // req dropped, ack drops next cycle
          state_q    <= release_bus;
          load_ack_q <= 1'b0;
        end
        grant_dump: if (!dump_req_i) begin
          state_q    <= release_bus;
          dump_ack_q <= 1'b0;
        end
        release_bus: state_q <= free; // acks are low now
        default:     state_q <= free;
      endcase
    end
  end

endmodule

/* hdl/hex_loader.sv */
// ignores all before SOT, then fills addresses 0..DEPTH-1 in order; non-hex chars are skipped
module hex_loader #(
  parameter int  WORD_NIBBLES = 4,
  parameter int  DEPTH        = 16,
  localparam int WW           = 4 * WORD_NIBBLES,
  localparam int AW           = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int NW           = (WORD_NIBBLES > 1) ? $clog2(WORD_NIBBLES) : 1
) (
  input  logic             clk_sys,
  input  logic             rst_clk,
  input  hexio_pkg::char_t rx_char_i,
  input  logic             rx_rdy_i,
  output logic             rx_pop_o,
  output logic             req_o,
  output logic [AW-1:0]    addr_o,
  output logic [WW-1:0]    wdata_o,
  input  logic             ack_i,
  output logic             load_done_o
);
  import hexio_pkg::*;

  loader_state_e state_q;
  logic [AW-1:0] addr_q;
  logic [WW-1:0] word_q;    // nibbles shift in from the right
  logic [NW-1:0] nib_cnt_q; // nibbles collected in current word
  logic [4:0]    digit;     // {valid, value}
  logic          take;      // char consumed this cycle
  logic          done_q;

  assign digit = hex_to_nibble(rx_char_i);
  // pops in wait_sot and collect only, write handshake stalls the stream
  assign take  = rx_rdy_i && (state_q == wait_sot || state_q == collect);

  assign rx_pop_o    = take;
  assign req_o       = (state_q == write_req);
  assign addr_o      = addr_q;
  assign wdata_o     = word_q;
  assign load_done_o = done_q;

  // ************************************************************************
  // control
  // ************************************************************************
  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      state_q   <= wait_sot;
      addr_q    <= '0;
      nib_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0; // single-cycle pulse
      case (state_q)
        wait_sot: if (take && rx_char_i == ch_sot) begin
          state_q   <= collect;
          addr_q    <= '0;
          nib_cnt_q <= '0;
        end
        collect: if (take && digit[4]) begin
          if (nib_cnt_q == NW'(WORD_NIBBLES - 1)) begin
            nib_cnt_q <= '0;
            state_q   <= write_req; // word complete
          end else begin
            nib_cnt_q <= nib_cnt_q + 1'b1;
          end
        end
        write_req: if (ack_i) state_q <= write_wait; // req drops next cycle
        write_wait: if (!ack_i) begin
          if (addr_q == AW'(DEPTH - 1)) begin
            done_q  <= 1'b1;
            state_q <= wait_sot; // image full
          end else begin
            addr_q  <= addr_q + 1'b1;
            state_q <= collect;
          end
        end
        default: state_q <= wait_sot;
      endcase
    end
  end

  // word assembly, msb nibble arrives first
  always_ff @(posedge clk_sys) begin
    if (state_q == collect && take && digit[4]) begin
      word_q <= (word_q << 4) | WW'(digit[3:0]);
    end
  end

endmodule

/* hdl/hex_dumper.sv */
// start is ignored while busy; every char waits for tx_full_i low, file name is fixed '0'
module hex_dumper #(
  parameter int  WORD_NIBBLES = 4,
  parameter int  DEPTH        = 16,
  localparam int WW           = 4 * WORD_NIBBLES,
  localparam int AW           = (DEPTH > 1) ? $clog2(DEPTH) : 1,
  localparam int CW           = $clog2(WORD_NIBBLES + 2)
) (
  input  logic             clk_sys,
  input  logic             rst_clk,
  input  logic             dump_start_i,
  output logic             dump_busy_o,
  output logic             dump_done_o,
  output logic             req_o,
  output logic [AW-1:0]    addr_o,
  input  logic             ack_i,
  input  logic [WW-1:0]    rdata_i,
  output hexio_pkg::char_t tx_char_o,
  output logic             tx_we_o,
  input  logic             tx_full_i
);
  import hexio_pkg::*;

  dumper_state_e state_q;
  logic [AW-1:0] addr_q;
  logic [CW-1:0] cnt_q;   // char index within header or line
  logic [WW-1:0] word_q;  // latched word, shifted left per digit sent
  logic          emit;    // a char goes to the tx fifo this cycle
  logic          done_q;

  assign emit = !tx_full_i && (state_q == header || state_q == line || state_q == trailer);

  assign tx_we_o     = emit;
  assign req_o       = (state_q == read_req);
  assign addr_o      = addr_q;
  assign dump_done_o = done_q;
  assign dump_busy_o = (state_q != idle) || done_q; // covers the done cycle too

  // ************************************************************************
  // character select
  // ************************************************************************
  always_comb begin
    tx_char_o = ch_eof; // trailer
    case (state_q)
      header: begin
        case (cnt_q[1:0])
          2'd0:    tx_char_o = ch_soh;
          2'd1:    tx_char_o = ch_file_id;
          2'd2:    tx_char_o = ch_eot;
          default: tx_char_o = ch_sot;
        endcase
      end
      line: begin
        if (cnt_q < CW'(WORD_NIBBLES)) begin
          tx_char_o = nibble_to_hex(word_q[WW-1 -: 4]); // top nibble first
        end else if (cnt_q == CW'(WORD_NIBBLES)) begin
          tx_char_o = ch_cr;
        end else begin
          tx_char_o = ch_lf;
        end
      end
      default: tx_char_o = ch_eof;
    endcase
  end

  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      state_q <= idle;
      addr_q  <= '0;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        idle: if (dump_start_i && !done_q) begin
          state_q <= header;
          addr_q  <= '0;
          cnt_q   <= '0;
        end
        header: if (emit) begin
          if (cnt_q == CW'(3)) begin
            cnt_q   <= '0;
            state_q <= read_req;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        read_req:  if (ack_i) state_q <= read_wait; // word latched below
        read_wait: if (!ack_i) state_q <= line;     // handshake closed
        line: if (emit) begin
          if (cnt_q == CW'(WORD_NIBBLES + 1)) begin // LF just went out
            cnt_q <= '0;
            if (addr_q == AW'(DEPTH - 1)) begin
              state_q <= trailer;
            end else begin
              addr_q  <= addr_q + 1'b1;
              state_q <= read_req;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        trailer: if (emit) begin
          state_q <= idle;
          done_q  <= 1'b1; // pulse after EOF write
        end
        default: state_q <= idle;
      endcase
    end
  end

  // payload only
  always_ff @(posedge clk_sys) begin
    if (state_q == read_req && ack_i) begin
      word_q <= rdata_i;
    end else if (state_q == line && emit && cnt_q < CW'(WORD_NIBBLES)) begin
      word_q <= word_q << 4;
    end
  end

endmodule

/* hdl/hexio_top.sv */
// one shared ram; a load and a dump may overlap, the arbiter serializes their accesses
module hexio_top #(
  parameter int WORD_NIBBLES = 4, // hex digits per word
  parameter int DEPTH        = 16 // words
) (
  input  logic             clk_sys,
  input  logic             rst_clk,
  input  hexio_pkg::char_t rx_char_i,
  input  logic             rx_rdy_i,
  output logic             rx_pop_o,
  output hexio_pkg::char_t tx_char_o,
  output logic             tx_we_o,
  input  logic             tx_full_i,
  input  logic             dump_start_i,
  output logic             dump_busy_o,
  output logic             load_done_o,
  output logic             dump_done_o
);

  localparam int WW = 4 * WORD_NIBBLES;
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // ************************************************************************
  // client and ram buses
  // ************************************************************************
  logic          load_req,  load_ack;
  logic [AW-1:0] load_addr;
  logic [WW-1:0] load_wdata;
  logic          dump_req,  dump_ack;
  logic [AW-1:0] dump_addr;
  logic [WW-1:0] dump_rdata;
  logic          ram_we;
  logic [AW-1:0] ram_addr;
  logic [WW-1:0] ram_wdata, ram_rdata;

  hex_loader #(.WORD_NIBBLES(WORD_NIBBLES), .DEPTH(DEPTH)) u_hex_loader (
    .clk_sys, .rst_clk, .rx_char_i, .rx_rdy_i, .rx_pop_o,
    .req_o(load_req), .addr_o(load_addr), .wdata_o(load_wdata), .ack_i(load_ack),
    .load_done_o
  );

  hex_dumper #(.WORD_NIBBLES(WORD_NIBBLES), .DEPTH(DEPTH)) u_hex_dumper (
    .clk_sys, .rst_clk, .dump_start_i, .dump_busy_o, .dump_done_o,
    .req_o(dump_req), .addr_o(dump_addr), .ack_i(dump_ack), .rdata_i(dump_rdata),
    .tx_char_o, .tx_we_o, .tx_full_i
  );

  mem_arbiter #(.WORD_NIBBLES(WORD_NIBBLES), .DEPTH(DEPTH)) u_mem_arbiter (
    .clk_sys, .rst_clk,
    .load_req_i(load_req), .load_addr_i(load_addr), .load_wdata_i(load_wdata),
    .load_ack_o(load_ack),
    .dump_req_i(dump_req), .dump_addr_i(dump_addr), .dump_ack_o(dump_ack),
    .dump_rdata_o(dump_rdata),
    .ram_we_o(ram_we), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
    .ram_rdata_i(ram_rdata)
  );

  word_ram #(.WORD_NIBBLES(WORD_NIBBLES), .DEPTH(DEPTH)) u_word_ram (
    .clk_sys, .we_i(ram_we), .addr_i(ram_addr), .wdata_i(ram_wdata), .rdata_o(ram_rdata)
  );

endmodule

/* tb/hexio_checker.sv */
// one file expected per dump; the image must be set before the dump it is compared with
module hexio_checker #(
  parameter int WORD_NIBBLES = 4,
  parameter int DEPTH        = 16
) (
  input logic             clk_sys,
  input logic             rst_clk,
  input logic             quiet_i,     // no stimulus applied yet
  input logic             rx_pop_i,
  input hexio_pkg::char_t tx_char_i,
  input logic             tx_we_i,
  input logic             tx_full_i,
  input logic             dump_busy_i,
  input logic             load_done_i,
  input logic             dump_done_i
);
  import hexio_pkg::*;

  localparam int WW       = 4 * WORD_NIBBLES;
  localparam int LINE_LEN = WORD_NIBBLES + 2;   // digits, CR, LF
  localparam int FILE_LEN = 5 + DEPTH * LINE_LEN;

  logic [WW-1:0] exp_mem [DEPTH]; // expected image
  int            idx = 0;         // next char position in the file
  logic          load_armed = 1'b0;
  logic          dump_armed = 1'b0;
  int            mismatch_cnt = 0;
  int            other_cnt = 0;

  task automatic set_word(input int a, input logic [WW-1:0] w);
    exp_mem[a] = w;
  endtask

  task automatic expect_load;
    load_armed = 1'b1;
  endtask

  task automatic expect_dump;
    dump_armed = 1'b1;
    idx        = 0;
  endtask

  task automatic report_fault(input string msg);
    other_cnt++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_low(input string name, input logic v);
    if (v !== 1'b0) begin
      mismatch_cnt++;
      $display("Mismatch %s: expected 0, got %h", name, v);
    end
  endtask

  // ************************************************************************
  // reference: n-th character of the file for the expected image
  // ************************************************************************
  function automatic char_t ref_char(input int n);
    int            row;
    int            pos;
    logic [3:0]    nib;
    if (n == 0) return ch_soh;
    if (n == 1) return ch_file_id;
    if (n == 2) return ch_eot;
    if (n == 3) return ch_sot;
    if (n == FILE_LEN - 1) return ch_eof;
    row = (n - 4) / LINE_LEN;
    pos = (n - 4) % LINE_LEN;
    if (pos == WORD_NIBBLES) return ch_cr;
    if (pos == WORD_NIBBLES + 1) return ch_lf;
    nib = 4'(exp_mem[row] >> (4 * (WORD_NIBBLES - 1 - pos))); // msb digit first
    return (nib < 4'd10) ? 8'h30 + nib : 8'h41 + nib - 4'd10;
  endfunction

  always @(posedge clk_sys) begin
    if (!rst_clk) begin
      if (quiet_i) begin // nothing may move before stimulus
        check_low("rx_pop_o", rx_pop_i);
        check_low("tx_we_o", tx_we_i);
        check_low("dump_busy_o", dump_busy_i);
        check_low("load_done_o", load_done_i);
        check_low("dump_done_o", dump_done_i);
      end
      if (tx_we_i === 1'b1) begin
        if (tx_full_i) report_fault("tx_we_o asserted while tx_full_i is high");
        if (!dump_armed || idx >= FILE_LEN) begin
          report_fault($sformatf("character %h written outside an expected file", tx_char_i));
        end else begin
          if (tx_char_i !== ref_char(idx)) begin
            mismatch_cnt++;
            $display("Mismatch tx_char_o at char %0d: expected %h, got %h",
                     idx, ref_char(idx), tx_char_i);
          end
          idx++;
        end
      end
      if (dump_done_i === 1'b1) begin
        if (!dump_armed) report_fault("dump_done_o pulsed with no dump running");
        else if (idx != FILE_LEN) begin
          report_fault($sformatf("dump_done_o after %0d of %0d characters", idx, FILE_LEN));
        end
        dump_armed = 1'b0; // second pulse would be unexpected
      end
      if (load_done_i === 1'b1) begin
        if (!load_armed) report_fault("load_done_o pulsed with no load pending");
        load_armed = 1'b0;
      end
    end
  end

endmodule

/* tb/tb_hexio_top.sv */
// default parameters; word draws take at most 32 lfsr bits, so WORD_NIBBLES must stay <= 8
module tb_hexio_top;
  import hexio_pkg::*;

  localparam int WN       = 4;
  localparam int DEPTH    = 16;
  localparam int WW       = 4 * WN;
  localparam int FILE_LEN = 5 + DEPTH * (WN + 2);
  localparam int RX_MAX   = 16 + DEPTH * (2 * WN + 2); // junk plus a space after every digit
  localparam int LIMIT    = (3 * RX_MAX + 4 * FILE_LEN) * 8 + 200; // 3 loads, 4 dumps

  logic        clk_sys, rst_clk;
  char_t       rx_char_i, tx_char_o;
  logic        rx_rdy_i, rx_pop_o, tx_we_o, tx_full_i;
  logic        dump_start_i, dump_busy_o, load_done_o, dump_done_o;
  logic        quiet;       // high until the first load is queued
  logic        bp_on;       // random tx_full_i enable
  logic [15:0] word_lfsr, full_lfsr;
  char_t       rx_q [$];    // receive fifo contents, head is rx_char_i
  int          cycles, tb_errs;

  hexio_top #(.WORD_NIBBLES(WN), .DEPTH(DEPTH)) u_hexio_top (
    .clk_sys, .rst_clk, .rx_char_i, .rx_rdy_i, .rx_pop_o, .tx_char_o, .tx_we_o,
    .tx_full_i, .dump_start_i, .dump_busy_o, .load_done_o, .dump_done_o
  );

  hexio_checker #(.WORD_NIBBLES(WN), .DEPTH(DEPTH)) u_hexio_checker (
    .clk_sys, .rst_clk, .quiet_i(quiet), .rx_pop_i(rx_pop_o), .tx_char_i(tx_char_o),
    .tx_we_i(tx_we_o), .tx_full_i, .dump_busy_i(dump_busy_o), .load_done_i(load_done_o),
    .dump_done_i(dump_done_o)
  );

  // taps of x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at the bottom
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      word_lfsr = lfsr_step(word_lfsr); // one step per bit
      v = {v[30:0], word_lfsr[0]};
    end
  endtask

  function automatic char_t hex_char(input logic [3:0] n, input logic lower);
    if (n < 4'd10) return 8'h30 + n;
    return (lower ? 8'h61 : 8'h41) + n - 4'd10;
  endfunction

  // ************************************************************************
  // stimulus tasks
  // ************************************************************************
  // new random image; messy adds junk before SOT, lower case and spaces
  task automatic load_image(input logic messy);
    logic [31:0]   r;
    logic [WW-1:0] w;
    @(posedge clk_sys);
    #10;
    u_hexio_checker.expect_load();
    rx_q.push_back(ch_soh);
    rx_q.push_back(ch_file_id); // hex digit that the loader drops before SOT
    rx_q.push_back(ch_eot);
    if (messy) begin
      rx_q.push_back("q");
      rx_q.push_back("7");
      rx_q.push_back("b");
      rx_q.push_back(" ");
    end
    rx_q.push_back(ch_sot);
    for (int a = 0; a < DEPTH; a++) begin
      take_bits(WW, r);
      w = r[WW-1:0];
      u_hexio_checker.set_word(a, w);
      for (int d = WN - 1; d >= 0; d--) begin
        take_bits(2, r);
        rx_q.push_back(hex_char(w[4*d +: 4], messy & r[0]));
        if (messy && r[1]) rx_q.push_back(" ");
      end
      rx_q.push_back(ch_cr);
      rx_q.push_back(ch_lf);
    end
    rx_q.push_back(ch_eof); // loader is back in wait_sot by now
  endtask

  task automatic pulse_start;
    @(posedge clk_sys);
    #10 dump_start_i = 1'b1;
    @(posedge clk_sys);
    #10 dump_start_i = 1'b0;
  endtask

  task automatic start_dump;
    @(posedge clk_sys);
    #10 u_hexio_checker.expect_dump(); // armed away from the edge
    pulse_start();
  endtask

  task automatic wait_done(input logic dump);
    do @(posedge clk_sys); while ((dump ? dump_done_o : load_done_o) !== 1'b1);
  endtask

  initial begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  // rx fifo model and tx full source drive 10 after the edge
  initial begin
    forever begin
      @(posedge clk_sys);
      if (rx_pop_o === 1'b1 && rx_q.size() > 0) void'(rx_q.pop_front());
      #10;
      rx_rdy_i  = (rx_q.size() > 0);
      rx_char_i = (rx_q.size() > 0) ? rx_q[0] : 8'h00;
      full_lfsr = lfsr_step(full_lfsr);
      tx_full_i = bp_on & full_lfsr[0];
    end
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk_sys);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    rst_clk      = 1'b1;
    rx_char_i    = 8'h00;
    rx_rdy_i     = 1'b0;
    tx_full_i    = 1'b0;
    dump_start_i = 1'b0;
    quiet        = 1'b1;
    bp_on        = 1'b0;
    word_lfsr    = 16'd33;
    full_lfsr    = 16'd33;
    tb_errs      = 0;
    repeat (4) @(posedge clk_sys);
    #10 rst_clk = 1'b0;
    repeat (6) @(posedge clk_sys); // outputs must stay low in this idle window
    #10 quiet = 1'b0;
    load_image(1'b0);              // clean load, then dump
    wait_done(1'b0);
    start_dump();
    wait_done(1'b1);
    load_image(1'b1);              // tolerant parsing
    wait_done(1'b0);
    start_dump();
    wait_done(1'b1);
    bp_on = 1'b1;                  // same image under back-pressure
    start_dump();
    wait_done(1'b1);
    load_image(1'b0);              // reload overwrites
    wait_done(1'b0);
    start_dump();
    repeat (10) @(posedge clk_sys);
    if (dump_busy_o !== 1'b1) begin
      tb_errs++;
      $display("Mismatch dump_busy_o: expected 1, got %h", dump_busy_o);
    end
    pulse_start();                 // ignored while busy
    wait_done(1'b1);
    repeat (40) @(posedge clk_sys); // a second file would show up here
    $display("errors: %0d mismatch, %0d other", u_hexio_checker.mismatch_cnt + tb_errs,
             u_hexio_checker.other_cnt);
    if (u_hexio_checker.mismatch_cnt + tb_errs == 0 && u_hexio_checker.other_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* hexio_top.f */
hdl/hexio_pkg.sv
hdl/word_ram.sv
hdl/mem_arbiter.sv
hdl/hex_loader.sv
hdl/hex_dumper.sv
hdl/hexio_top.sv
tb/hexio_checker.sv
tb/tb_hexio_top.sv
